// ==== Bender.yml ====
package:
  name: rmt_wrapper

sources:
  - verilog/rmt_pkg.sv
  - verilog/pkt_parser.sv
  - verilog/match_table.sv
  - verilog/beat_fifo.sv
  - verilog/deparser.sv
  - verilog/rmt_wrapper.sv
  - target: test
    files:
      - bench/rmt_wrapper_props.sv
      - bench/tb_rmt_wrapper.sv

// ==== bench/rmt_wrapper_props.sv ====
`default_nettype none

module rmt_wrapper_props
    import rmt_pkg::*;
(
    input wire                   clk,
    input wire                   rst,
    input wire [data_width-1:0]  m_axis_tdata,
    input wire [keep_width-1:0]  m_axis_tkeep,
    input wire [user_width-1:0]  m_axis_tuser,
    input wire                   m_axis_tvalid,
    input wire                   m_axis_tready,
    input wire                   m_axis_tlast,
    input wire                   s_axis_tready,
    input wire                   fifo_wr,
    input wire                   fifo_full
);

    int fail_count = 0;

    // a stalled master beat holds until taken
    assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tkeep) && $stable(m_axis_tuser) && $stable(m_axis_tlast))
    else begin
        fail_count++;
        $error("master beat changed before it was accepted");
    end

    assert property (@(posedge clk) rst |=> !m_axis_tvalid)
    else begin
        fail_count++;
        $error("m_axis_tvalid high after reset");
    end

    // every FIFO write is an accepted beat that still finds a free slot
    assert property (@(posedge clk) disable iff (rst)
        fifo_wr |-> s_axis_tready && !fifo_full)
    else begin
        fail_count++;
        $error("beat written into the FIFO while s_axis_tready was low or the FIFO was full");
    end

endmodule

bind rmt_wrapper rmt_wrapper_props props_i (
    .clk           (clk),
    .rst           (rst),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .fifo_wr       (fifo_i.wr_en),
    .fifo_full     (fifo_i.full)
);

`default_nettype wire

// ==== bench/tb_rmt_wrapper.sv ====
`default_nettype none

module tb_rmt_wrapper;
    import rmt_pkg::*;

    localparam int max_len         = 4;
    localparam int num_random      = 24;
    localparam int num_packets     = 7 + 2 * num_random;
    localparam int watchdog_cycles = num_packets * max_len * 40;

    logic                        clk;
    logic                        rst;
    logic [data_width-1:0]       s_axis_tdata;
    logic [keep_width-1:0]       s_axis_tkeep;
    logic [user_width-1:0]       s_axis_tuser;
    logic                        s_axis_tvalid;
    logic                        s_axis_tready;
    logic                        s_axis_tlast;
    logic [data_width-1:0]       m_axis_tdata;
    logic [keep_width-1:0]       m_axis_tkeep;
    logic [user_width-1:0]       m_axis_tuser;
    logic                        m_axis_tvalid;
    logic                        m_axis_tready;
    logic                        m_axis_tlast;
    logic                        tbl_wr;
    logic [table_addr_width-1:0] tbl_addr;
    logic [key_width-1:0]        tbl_key;
    action_t                     tbl_action;
    logic [port_width-1:0]       tbl_arg;

    int   seed       = 32'he4f0_1648;
    int   ready_seed = 32'he4f0_1648;
    logic bp_on;
    int   sel;
    int   len;
    logic [key_width-1:0] key;

    // table model mirroring every write
    logic                  mdl_valid  [table_depth];
    logic [key_width-1:0]  mdl_key    [table_depth];
    action_t               mdl_action [table_depth];
    logic [port_width-1:0] mdl_arg    [table_depth];

    logic [data_width-1:0] pkt_data [max_len];
    logic [keep_width-1:0] pkt_keep [max_len];
    logic [user_width-1:0] pkt_user [max_len];
    logic [key_width-1:0]  known_keys [5] = '{12'h101, 12'h202, 12'h303, 12'h404, 12'h555};

    logic [data_width-1:0] exp_data [$];
    logic [keep_width-1:0] exp_keep [$];
    logic [user_width-1:0] exp_user [$];
    logic                  exp_last [$];

    rmt_wrapper rmt_wrapper_i (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .tbl_wr        (tbl_wr),
        .tbl_addr      (tbl_addr),
        .tbl_key       (tbl_key),
        .tbl_action    (tbl_action),
        .tbl_arg       (tbl_arg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] actual,
            input logic [data_width-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lookup and action rules applied to the packet in pkt_*
    function automatic void expected_packet(input int n);
        logic [key_width-1:0]  pkt_key;
        logic                  hit;
        action_t               act;
        logic [port_width-1:0] arg;
        logic [data_width-1:0] data;
        logic [user_width-1:0] user;
        pkt_key = pkt_data[0][key_lsb +: key_width];
        hit = 1'b0;
        act = act_forward;
        arg = '0;
        for (int i = 0; i < table_depth; i++) begin
            if (!hit && mdl_valid[i] && mdl_key[i] == pkt_key) begin
                hit = 1'b1;
                act = mdl_action[i];
                arg = mdl_arg[i];
            end
        end
        if (act == act_drop) begin
            return;
        end
        for (int b = 0; b < n; b++) begin
            data = pkt_data[b];
            user = pkt_user[b];
            if (b == 0 && act == act_rewrite) begin
                data[key_lsb +: key_width] = key_width'(arg);
                user[dport_lsb +: port_width] = '0;
            end else if (b == 0) begin
                user[dport_lsb +: port_width] = arg;
            end
            exp_data.push_back(data);
            exp_keep.push_back(pkt_keep[b]);
            exp_user.push_back(user);
            exp_last.push_back(b == n - 1);
        end
    endfunction

    task automatic write_entry(input int addr, input logic [key_width-1:0] k,
            input action_t act, input logic [port_width-1:0] arg);
        s_axis_tvalid <= 1'b0;
        tbl_wr        <= 1'b1;
        tbl_addr      <= addr;
        tbl_key       <= k;
        tbl_action    <= act;
        tbl_arg       <= arg;
        @(posedge clk);
        tbl_wr <= 1'b0;
        mdl_valid[addr]  = 1'b1;
        mdl_key[addr]    = k;
        mdl_action[addr] = act;
        mdl_arg[addr]    = arg;
    endtask

    task automatic send_packet(input logic [key_width-1:0] k, input int n);
        for (int b = 0; b < n; b++) begin
            for (int w = 0; w < data_width / 32; w++) begin
                pkt_data[b][w*32 +: 32] = $random(seed);
            end
            for (int w = 0; w < user_width / 32; w++) begin
                pkt_user[b][w*32 +: 32] = $random(seed);
            end
            pkt_keep[b] = {$random(seed), $random(seed)};
        end
        pkt_data[0][key_lsb +: key_width] = k;
        expected_packet(n);
        for (int b = 0; b < n; b++) begin
            s_axis_tdata  <= pkt_data[b];
            s_axis_tkeep  <= pkt_keep[b];
            s_axis_tuser  <= pkt_user[b];
            s_axis_tlast  <= (b == n - 1);
            s_axis_tvalid <= 1'b1;
            @(posedge clk);
            while (!s_axis_tready) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic send_random(input int count);
        for (int p = 0; p < count; p++) begin
            sel = $unsigned($random(seed)) % 6;
            key = (sel < 5) ? known_keys[sel] : key_width'($random(seed));
            len = 1 + $unsigned($random(seed)) % max_len;
            send_packet(key, len);
        end
    endtask

    always @(posedge clk) begin
        if (bp_on) begin
            m_axis_tready <= $random(ready_seed) & 1;
        end else begin
            m_axis_tready <= 1'b1;
        end
    end

    // scoreboard
    always @(posedge clk) begin
        if (!rst && m_axis_tvalid && m_axis_tready) begin
            if (exp_data.size() == 0) begin
                fail_run("output beat appeared while no packet was expected");
            end else begin
                check_value("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
                check_value("m_axis_tkeep", m_axis_tkeep, exp_keep.pop_front());
                check_value("m_axis_tuser", m_axis_tuser, exp_user.pop_front());
                check_value("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired, output stalled before all packets came out");
    end

    initial begin
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b1;
        tbl_wr        = 1'b0;
        tbl_addr      = '0;
        tbl_key       = '0;
        tbl_action    = act_forward;
        tbl_arg       = '0;
        bp_on         = 1'b0;
        for (int i = 0; i < table_depth; i++) begin
            mdl_valid[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("s_axis_tready", s_axis_tready, 1'b1);
        // entry 3 is shadowed by entry 0
        write_entry(0, 12'h101, act_forward, 8'h05);
        write_entry(1, 12'h202, act_rewrite, 8'h3c);
        write_entry(2, 12'h303, act_drop, 8'h00);
        write_entry(3, 12'h101, act_drop, 8'h00);
        write_entry(4, 12'h404, act_forward, 8'h09);
        send_packet(12'h101, 2);
        send_packet(12'h202, 3);
        send_packet(12'h303, 2);
        send_packet(12'h555, 1);
        send_packet(12'h404, 4);
        bp_on <= 1'b1;
        send_random(num_random);
        write_entry(2, 12'h303, act_forward, 8'h07);
        write_entry(0, 12'h101, act_rewrite, 8'h11);
        send_packet(12'h303, 2);
        send_packet(12'h101, 3);
        send_random(num_random);
        s_axis_tvalid <= 1'b0;
        while (exp_data.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (exp_data.size() == 0 && !m_axis_tvalid && rmt_wrapper_i.props_i.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "extra output or assertion failures at end of run");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/rmt_pkg.sv
verilog/pkt_parser.sv
verilog/match_table.sv
verilog/beat_fifo.sv
verilog/deparser.sv
verilog/rmt_wrapper.sv
bench/rmt_wrapper_props.sv
bench/tb_rmt_wrapper.sv

// ==== verilog/beat_fifo.sv ====
`default_nettype none

module beat_fifo
    import rmt_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wr_en,
    input  wire [beat_width-1:0]   wr_data,
    input  wire                    rd_en,
    output logic                   rd_valid,
    output logic [beat_width-1:0]  rd_data,
    output logic                   almost_full
);

    logic [beat_width-1:0]      mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0]   count;
    logic                       full;
    logic                       push;
    logic                       pop;

    assign full = count == fifo_depth;
    assign push = wr_en && !full;
    assign pop  = rd_en && rd_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_valid = count != '0;
    assign rd_data  = mem[rd_ptr];

    // two slots of margin before full
    assign almost_full = count >= fifo_depth - 2;

endmodule

`default_nettype wire

// ==== verilog/deparser.sv ====
`default_nettype none

module deparser
    import rmt_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    res_valid,
    input  var  action_t           res_action,
    input  wire [port_width-1:0]   res_arg,
    input  wire                    rd_valid,
    input  wire [beat_width-1:0]   rd_data,
    input  wire                    m_axis_tready,
    output logic                   res_pop,
    output logic                   rd_en,
    output logic [data_width-1:0]  m_axis_tdata,
    output logic [keep_width-1:0]  m_axis_tkeep,
    output logic [user_width-1:0]  m_axis_tuser,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast
);

    dstate_t               state;
    logic [data_width-1:0] next_tdata;
    logic [user_width-1:0] next_tuser;
    logic                  in_tlast;
    logic                  out_free;
    logic                  emit;

    assign in_tlast = rd_data[last_bit];
    assign out_free = !m_axis_tvalid || m_axis_tready;

    // drops drain without waiting for the output register
    assign rd_en   = res_valid && rd_valid && (res_action == act_drop || out_free);
    assign emit    = rd_en && res_action != act_drop;
    assign res_pop = rd_en && in_tlast;

    always_comb begin
        next_tdata = rd_data[data_width-1:0];
        next_tuser = rd_data[user_lsb +: user_width];
        if (state == ds_head) begin
            if (res_action == act_rewrite) begin
                next_tdata[key_lsb +: key_width] = {{(key_width - port_width){1'b0}}, res_arg};
                next_tuser[dport_lsb +: port_width] = '0;
            end else begin
                next_tuser[dport_lsb +: port_width] = res_arg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ds_head;
        end else if (rd_en) begin
            state <= in_tlast ? ds_head : ds_body;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_axis_tvalid <= 1'b0;
        end else if (emit) begin
            m_axis_tvalid <= 1'b1;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            m_axis_tdata <= next_tdata;
            m_axis_tkeep <= rd_data[keep_lsb +: keep_width];
            m_axis_tuser <= next_tuser;
            m_axis_tlast <= in_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/match_table.sv ====
`default_nettype none

module match_table
    import rmt_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         tbl_wr,
    input  wire [table_addr_width-1:0]  tbl_addr,
    input  wire [key_width-1:0]         tbl_key,
    input  var  action_t                tbl_action,
    input  wire [port_width-1:0]        tbl_arg,
    input  wire                         key_valid,
    input  wire [key_width-1:0]         key,
    input  wire                         res_pop,
    output logic                        res_valid,
    output action_t                     res_action,
    output logic [port_width-1:0]       res_arg,
    output logic                        res_full
);

    logic                         ent_valid  [table_depth];
    logic [key_width-1:0]         ent_key    [table_depth];
    action_t                      ent_action [table_depth];
    logic [port_width-1:0]        ent_arg    [table_depth];

    logic                         hit;
    action_t                      hit_action;
    logic [port_width-1:0]        hit_arg;

    action_t                      rq_action [result_depth];
    logic [port_width-1:0]        rq_arg    [result_depth];
    logic [result_addr_width-1:0] rq_wr_ptr;
    logic [result_addr_width-1:0] rq_rd_ptr;
    logic [result_addr_width:0]   rq_count;
    logic                         push;
    logic                         pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < table_depth; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (tbl_wr) begin
            ent_valid[tbl_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr) begin
            ent_key[tbl_addr]    <= tbl_key;
            ent_action[tbl_addr] <= tbl_action;
            ent_arg[tbl_addr]    <= tbl_arg;
        end
    end

    // lowest index wins, a miss means forward to port 0
    always_comb begin
        hit        = 1'b0;
        hit_action = act_forward;
        hit_arg    = '0;
        for (int i = 0; i < table_depth; i++) begin
            if (!hit && ent_valid[i] && ent_key[i] == key) begin
                hit        = 1'b1;
                hit_action = ent_action[i];
                hit_arg    = ent_arg[i];
            end
        end
    end

    assign push = key_valid && (rq_count != result_depth);
    assign pop  = res_pop && res_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rq_wr_ptr <= '0;
            rq_rd_ptr <= '0;
            rq_count  <= '0;
        end else begin
            if (push) begin
                rq_wr_ptr <= rq_wr_ptr + 1'b1;
            end
            if (pop) begin
                rq_rd_ptr <= rq_rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   rq_count <= rq_count + 1'b1;
                2'b01:   rq_count <= rq_count - 1'b1;
                default: rq_count <= rq_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rq_action[rq_wr_ptr] <= hit_action;
            rq_arg[rq_wr_ptr]    <= hit_arg;
        end
    end

    assign res_valid  = rq_count != '0;
    assign res_action = rq_action[rq_rd_ptr];
    assign res_arg    = rq_arg[rq_rd_ptr];
    // one slot early, keeps room for the lookup of an accepted first beat
    assign res_full   = rq_count >= result_depth - 1;

endmodule

`default_nettype wire

// ==== verilog/pkt_parser.sv ====
`default_nettype none

module pkt_parser
    import rmt_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   beat_fire,
    input  wire [data_width-1:0]  tdata,
    input  wire                   tlast,
    output logic                  key_valid,
    output logic [key_width-1:0]  key
);

    logic first_beat;

    // next accepted beat opens a packet after reset and after every tlast
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
        end else if (beat_fire) begin
            first_beat <= tlast;
        end
    end

    assign key_valid = beat_fire && first_beat;

    // key sits in the phv of the first beat
    assign key = tdata[key_lsb +: key_width];

endmodule

`default_nettype wire

// ==== verilog/rmt_pkg.sv ====
`default_nettype none

package rmt_pkg;

    // stream widths
    localparam int data_width = 512;
    localparam int keep_width = data_width / 8;
    localparam int user_width = 128;

    // buffered beat layout, tdata in the low bits
    localparam int keep_lsb   = data_width;
    localparam int user_lsb   = keep_lsb + keep_width;
    localparam int last_bit   = user_lsb + user_width;
    localparam int beat_width = last_bit + 1;

    // header fields
    localparam int key_width  = 12;
    localparam int key_lsb    = 116;
    localparam int dport_lsb  = 24;
    localparam int port_width = 8;

    // table entry: valid, key, action, argument
    localparam int table_depth      = 16;
    localparam int table_addr_width = 4;

    localparam int fifo_depth      = 32;
    localparam int fifo_addr_width = 5;

    localparam int result_depth      = 4;
    localparam int result_addr_width = 2;

    typedef enum logic [1:0] {
        act_forward = 2'd0,
        act_rewrite = 2'd1,
        act_drop    = 2'd2
    } action_t;

    typedef enum logic {
        ds_head = 1'b0,
        ds_body = 1'b1
    } dstate_t;

endpackage

`default_nettype wire

// ==== verilog/rmt_wrapper.sv ====
`default_nettype none

module rmt_wrapper
    import rmt_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,

    input  wire [data_width-1:0]        s_axis_tdata,
    input  wire [keep_width-1:0]        s_axis_tkeep,
    input  wire [user_width-1:0]        s_axis_tuser,
    input  wire                         s_axis_tvalid,
    output logic                        s_axis_tready,
    input  wire                         s_axis_tlast,

    output logic [data_width-1:0]       m_axis_tdata,
    output logic [keep_width-1:0]       m_axis_tkeep,
    output logic [user_width-1:0]       m_axis_tuser,
    output logic                        m_axis_tvalid,
    input  wire                         m_axis_tready,
    output logic                        m_axis_tlast,

    input  wire                         tbl_wr,
    input  wire [table_addr_width-1:0]  tbl_addr,
    input  wire [key_width-1:0]         tbl_key,
    input  var  action_t                tbl_action,
    input  wire [port_width-1:0]        tbl_arg
);

    logic                  beat_fire;
    logic [beat_width-1:0] wr_beat;
    logic                  key_valid;
    logic [key_width-1:0]  key;
    logic                  res_valid;
    action_t               res_action;
    logic [port_width-1:0] res_arg;
    logic                  res_full;
    logic                  res_pop;
    logic                  rd_valid;
    logic [beat_width-1:0] rd_data;
    logic                  rd_en;
    logic                  fifo_almost_full;

    // room for the beat and for a possible lookup result
    assign s_axis_tready = !fifo_almost_full && !res_full;
    assign beat_fire     = s_axis_tvalid && s_axis_tready;
    assign wr_beat       = {s_axis_tlast, s_axis_tuser, s_axis_tkeep, s_axis_tdata};

    pkt_parser parser_i (
        .clk       (clk),
        .rst       (rst),
        .beat_fire (beat_fire),
        .tdata     (s_axis_tdata),
        .tlast     (s_axis_tlast),
        .key_valid (key_valid),
        .key       (key)
    );

    match_table table_i (
        .clk        (clk),
        .rst        (rst),
        .tbl_wr     (tbl_wr),
        .tbl_addr   (tbl_addr),
        .tbl_key    (tbl_key),
        .tbl_action (tbl_action),
        .tbl_arg    (tbl_arg),
        .key_valid  (key_valid),
        .key        (key),
        .res_pop    (res_pop),
        .res_valid  (res_valid),
        .res_action (res_action),
        .res_arg    (res_arg),
        .res_full   (res_full)
    );

    beat_fifo fifo_i (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (beat_fire),
        .wr_data     (wr_beat),
        .rd_en       (rd_en),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .almost_full (fifo_almost_full)
    );

    deparser deparser_i (
        .clk           (clk),
        .rst           (rst),
        .res_valid     (res_valid),
        .res_action    (res_action),
        .res_arg       (res_arg),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .m_axis_tready (m_axis_tready),
        .res_pop       (res_pop),
        .rd_en         (rd_en),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire
